// ==== rtl/vdp_reg_pkg.sv ====
// CPU-side register map of the VDP command engine.
// Imported by the register file, the sequencer and the testbench.
package vdp_reg_pkg;

  // Coordinate widths
  localparam int X_W = 9;
  localparam int Y_W = 10;

  // Register offsets as seen on the CPU port
  typedef enum logic [3:0] {
    REG_SX_LO = 4'd0,
    REG_SX_HI = 4'd1,
    REG_SY_LO = 4'd2,
    REG_SY_HI = 4'd3,
    REG_DX_LO = 4'd4,
    REG_DX_HI = 4'd5,
    REG_DY_LO = 4'd6,
    REG_DY_HI = 4'd7,
    REG_NX_LO = 4'd8,
    REG_NX_HI = 4'd9,
    REG_NY_LO = 4'd10,
    REG_NY_HI = 4'd11,
    REG_CLR   = 4'd12,
    REG_ARG   = 4'd13,
    REG_CMD   = 4'd14
  } reg_index_e;

  // Register block handed to the sequencer
  // NX and NY use the Y width so that counts up to 1023 fit
  typedef struct packed {
    logic [X_W-1:0] sx;
    logic [Y_W-1:0] sy;
    logic [X_W-1:0] dx;
    logic [Y_W-1:0] dy;
    logic [Y_W-1:0] nx;
    logic [Y_W-1:0] ny;
    logic [7:0]     clr;
    logic           dix;
    logic           diy;
    // Opcode in 7:4, transparency in 3, logic op in 2:0
    logic [7:0]     cmd;
  } cmd_regs_t;

endpackage

// ==== rtl/vdp_cmd_pkg.sv ====
// Command-side definitions: opcodes, logic ops, screen modes, FSM states, VRAM bundle.
// Imported by the sequencer, the pixel ALU and the top level.
package vdp_cmd_pkg;

  localparam int VRAM_ADDR_W = 17;

  // Opcodes from CMD bits 7:4, any other code acts as STOP
  typedef enum logic [3:0] {
    OP_STOP  = 4'b0000,
    OP_POINT = 4'b0100,
    OP_PSET  = 4'b0101,
    OP_LMMV  = 4'b1000,
    OP_HMMV  = 4'b1100
  } cmd_op_e;

  // Logic ops from CMD bits 2:0
  typedef enum logic [2:0] {
    LOG_IMP = 3'b000,
    LOG_AND = 3'b001,
    LOG_OR  = 3'b010,
    LOG_XOR = 3'b011,
    LOG_NOT = 3'b100
  } log_op_e;

  // G4 packs two pixels per byte, G7 one
  typedef enum logic {
    MODE_G4 = 1'b0,
    MODE_G7 = 1'b1
  } screen_mode_e;

  typedef enum logic [3:0] {
    IDLE,
    CHK_LOOP,
    PRE_RD,
    WAIT_PRE_RD,
    WR,
    WAIT_WR,
    RD,
    WAIT_RD,
    EXEC_END
  } seq_state_e;

  // Held stable while a VRAM access is outstanding
  typedef struct packed {
    logic [VRAM_ADDR_W-1:0] addr;
    logic [7:0]             wr_data;
  } vram_req_t;

endpackage

// ==== rtl/vdp_pixel_alu.sv ====
// Pixel datapath: pick the addressed pixel, apply the logic op, merge back into the byte.
`timescale 1ns/1ps

module vdp_pixel_alu (
  input  vdp_cmd_pkg::screen_mode_e mode,
  input  vdp_cmd_pkg::log_op_e      op,
  input  logic                      transparent,
  input  logic [7:0]                src_colour,
  input  logic [7:0]                rd_byte,
  input  logic                      x_low,
  output logic [7:0]                wr_byte,
  output logic [7:0]                point
);
  import vdp_cmd_pkg::*;

  logic [7:0] col_mask;
  logic [7:0] src;
  logic [7:0] result;

  // Even X sits in the high nibble in G4
  always_comb begin
    if (mode == MODE_G4) begin
      col_mask = 8'h0f;
      point    = x_low ? {4'h0, rd_byte[3:0]} : {4'h0, rd_byte[7:4]};
    end else begin
      col_mask = 8'hff;
      point    = rd_byte;
    end
  end

  assign src = src_colour & col_mask;

  always_comb begin
    // Transparent zero keeps the old pixel
    if (transparent && (src == 8'h00)) begin
      result = point;
    end else begin
      case (op)
        LOG_IMP: result = src;
        LOG_AND: result = src & point;
        LOG_OR:  result = src | point;
        LOG_XOR: result = src ^ point;
        LOG_NOT: result = ~src;
        default: result = point;
      endcase
    end
  end

  // Other nibble of the byte passes through untouched
  always_comb begin
    if (mode == MODE_G4) begin
      wr_byte = x_low ? {rd_byte[7:4], result[3:0]} : {result[3:0], rd_byte[3:0]};
    end else begin
      wr_byte = result;
    end
  end

endmodule

// ==== rtl/vdp_cmd_regs.sv ====
// Command register file behind the CPU toggle port.
// Pulses cmd_start on a CMD write and takes POINT results into CLR.
`timescale 1ns/1ps

module vdp_cmd_regs (
  input  logic                      clk,
  input  logic                      reset,
  input  vdp_cmd_pkg::screen_mode_e mode,
  input  logic                      reg_wr_req,
  input  vdp_reg_pkg::reg_index_e   reg_num,
  input  logic [7:0]                reg_data,
  input  logic                      clr_load_valid,
  input  logic [7:0]                clr_load_data,
  output logic                      reg_wr_ack,
  output vdp_reg_pkg::cmd_regs_t    regs,
  output logic                      cmd_start
);
  import vdp_reg_pkg::*;
  import vdp_cmd_pkg::*;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      regs       <= '0;
      reg_wr_ack <= 1'b0;
      cmd_start  <= 1'b0;
    end else begin
      // Start is a single-cycle pulse
      cmd_start <= 1'b0;
      // POINT result, overridden below by a CPU write to CLR
      if (clr_load_valid) begin
        regs.clr <= clr_load_data;
      end
      // Pending request, ack on this same edge
      if (reg_wr_req != reg_wr_ack) begin
        reg_wr_ack <= ~reg_wr_ack;
        case (reg_num)
          REG_SX_LO: regs.sx[7:0]     <= reg_data;
          REG_SX_HI: regs.sx[X_W-1:8] <= reg_data[X_W-9:0];
          REG_SY_LO: regs.sy[7:0]     <= reg_data;
          REG_SY_HI: regs.sy[Y_W-1:8] <= reg_data[Y_W-9:0];
          REG_DX_LO: regs.dx[7:0]     <= reg_data;
          REG_DX_HI: regs.dx[X_W-1:8] <= reg_data[X_W-9:0];
          REG_DY_LO: regs.dy[7:0]     <= reg_data;
          REG_DY_HI: regs.dy[Y_W-1:8] <= reg_data[Y_W-9:0];
          REG_NX_LO: regs.nx[7:0]     <= reg_data;
          REG_NX_HI: regs.nx[Y_W-1:8] <= reg_data[Y_W-9:0];
          REG_NY_LO: regs.ny[7:0]     <= reg_data;
          REG_NY_HI: regs.ny[Y_W-1:8] <= reg_data[Y_W-9:0];
          // Colour trimmed to the pixel width of the mode
          REG_CLR: regs.clr <= (mode == MODE_G4) ? {4'h0, reg_data[3:0]} : reg_data;
          REG_ARG: begin
            regs.dix <= reg_data[2];
            regs.diy <= reg_data[3];
          end
          // Aborts whatever runs and restarts the sequencer
          REG_CMD: begin
            regs.cmd  <= reg_data;
            cmd_start <= 1'b1;
          end
          default: begin
          end
        endcase
      end
    end
  end

endmodule

// ==== rtl/vdp_cmd_seq.sv ====
// Command sequencer: walks the rectangle, runs the VRAM toggle handshake, drives ce.
// Frozen while the CPU port takes a write, restarted by cmd_start.
`timescale 1ns/1ps

module vdp_cmd_seq (
  input  logic                      clk,
  input  logic                      reset,
  input  vdp_cmd_pkg::screen_mode_e mode,
  input  vdp_reg_pkg::cmd_regs_t    regs,
  input  logic                      cmd_start,
  input  logic                      stall,
  input  logic                      vram_rd_ack,
  input  logic                      vram_wr_ack,
  input  logic [7:0]                vram_rd_data,
  output logic                      vram_rd_req,
  output logic                      vram_wr_req,
  output vdp_cmd_pkg::vram_req_t    vram,
  output logic                      clr_load_valid,
  output logic [7:0]                clr_load_data,
  output logic                      ce
);
  import vdp_reg_pkg::*;
  import vdp_cmd_pkg::*;

  seq_state_e             state;
  cmd_op_e                op;
  logic                   first;
  logic [X_W:0]           dx_w;
  logic [Y_W-1:0]         dy_w;
  logic [Y_W:0]           nx_w;
  logic [Y_W:0]           ny_w;
  logic [Y_W:0]           nx_init;
  logic [Y_W:0]           ny_init;
  logic [X_W:0]           x_step;
  logic                   byte_mode;
  logic                   x_end;
  logic                   y_end;
  logic                   bus_idle;
  logic                   rd_x_low;
  logic [7:0]             merge_q;
  logic [7:0]             acc_x;
  logic [Y_W-1:0]         acc_y;
  logic [VRAM_ADDR_W-1:0] acc_addr;
  logic [7:0]             alu_wr_byte;
  logic [7:0]             alu_point;

  assign op = cmd_op_e'(regs.cmd[7:4]);
  // HMMV in G4 moves two pixels per byte
  assign byte_mode = (op == OP_HMMV) && (mode == MODE_G4);
  assign x_step = byte_mode ? {{(X_W-1){1'b0}}, 2'd2} : {{(X_W-1){1'b0}}, 2'd1};

  // Zero count means 1024
  always_comb begin
    nx_init = (regs.nx == '0) ? {1'b1, {Y_W{1'b0}}} : {1'b0, regs.nx};
    if (byte_mode) begin
      nx_init = nx_init >> 1;
    end
    ny_init = (regs.ny == '0) ? {1'b1, {Y_W{1'b0}}} : {1'b0, regs.ny};
  end

  // Bit 8 set once X steps past 255 either way
  assign x_end = (nx_w == '0) || dx_w[8];
  assign y_end = (ny_w == {{Y_W{1'b0}}, 1'b1}) || (regs.diy && (dy_w == '0));
  assign bus_idle = (vram_rd_req == vram_rd_ack) && (vram_wr_req == vram_wr_ack);

  // POINT reads at SX,SY, everything else at the working DX,DY
  assign acc_x = (op == OP_POINT) ? regs.sx[7:0] : dx_w[7:0];
  assign acc_y = (op == OP_POINT) ? regs.sy : dy_w;
  assign acc_addr = (mode == MODE_G4) ? {acc_y[9:0], acc_x[7:1]} : {acc_y[8:0], acc_x[7:0]};

  vdp_pixel_alu u_alu (
    .mode        (mode),
    .op          (log_op_e'(regs.cmd[2:0])),
    .transparent (regs.cmd[3]),
    .src_colour  (regs.clr),
    .rd_byte     (vram_rd_data),
    .x_low       (rd_x_low),
    .wr_byte     (alu_wr_byte),
    .point       (alu_point)
  );

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state          <= IDLE;
      ce             <= 1'b0;
      first          <= 1'b0;
      vram_rd_req    <= 1'b0;
      vram_wr_req    <= 1'b0;
      vram           <= '0;
      clr_load_valid <= 1'b0;
      clr_load_data  <= '0;
      dx_w           <= '0;
      dy_w           <= '0;
      nx_w           <= '0;
      ny_w           <= '0;
      rd_x_low       <= 1'b0;
      merge_q        <= '0;
    end else begin
      clr_load_valid <= 1'b0;
      // New command wins over a stall so the pulse is never lost
      if (cmd_start) begin
        first <= 1'b1;
        dx_w  <= {1'b0, regs.dx};
        dy_w  <= regs.dy;
        nx_w  <= nx_init;
        ny_w  <= ny_init;
        case (op)
          OP_HMMV, OP_LMMV, OP_PSET, OP_POINT: begin
            state <= CHK_LOOP;
            ce    <= 1'b1;
          end
          default: begin
            state <= IDLE;
            ce    <= 1'b0;
          end
        endcase
      end else if (!stall) begin
        case (state)
          IDLE: ce <= 1'b0;
          CHK_LOOP: begin
            first <= 1'b0;
            if (!first && x_end && y_end) begin
              state <= EXEC_END;
            end else begin
              case (op)
                OP_HMMV:          state <= WR;
                OP_LMMV, OP_PSET: state <= PRE_RD;
                OP_POINT:         state <= RD;
                default:          state <= EXEC_END;
              endcase
            end
            // Row done, step Y and reload X
            if (!first && x_end && !y_end) begin
              dx_w <= {1'b0, regs.dx};
              nx_w <= nx_init;
              ny_w <= ny_w - 1'b1;
              dy_w <= regs.diy ? dy_w - 1'b1 : dy_w + 1'b1;
            end
          end
          // Issue states hold off until any aborted access has drained
          PRE_RD: begin
            if (bus_idle) begin
              vram.addr   <= acc_addr;
              rd_x_low    <= acc_x[0];
              vram_rd_req <= ~vram_rd_req;
              state       <= WAIT_PRE_RD;
            end
          end
          WAIT_PRE_RD: begin
            if (vram_rd_req == vram_rd_ack) begin
              merge_q <= alu_wr_byte;
              state   <= WR;
            end
          end
          WR: begin
            if (bus_idle) begin
              vram.addr    <= acc_addr;
              vram.wr_data <= (op == OP_HMMV) ? regs.clr : merge_q;
              vram_wr_req  <= ~vram_wr_req;
              state        <= WAIT_WR;
            end
          end
          WAIT_WR: begin
            if (vram_wr_req == vram_wr_ack) begin
              if (op == OP_PSET) begin
                state <= EXEC_END;
              end else begin
                dx_w  <= regs.dix ? dx_w - x_step : dx_w + x_step;
                nx_w  <= nx_w - 1'b1;
                state <= CHK_LOOP;
              end
            end
          end
          RD: begin
            if (bus_idle) begin
              vram.addr   <= acc_addr;
              rd_x_low    <= acc_x[0];
              vram_rd_req <= ~vram_rd_req;
              state       <= WAIT_RD;
            end
          end
          // POINT result goes back to CLR as ce falls
          WAIT_RD: begin
            if (vram_rd_req == vram_rd_ack) begin
              clr_load_valid <= 1'b1;
              clr_load_data  <= alu_point;
              state          <= EXEC_END;
            end
          end
          EXEC_END: begin
            ce    <= 1'b0;
            state <= IDLE;
          end
          default: begin
            ce    <= 1'b0;
            state <= IDLE;
          end
        endcase
      end
    end
  end

endmodule

// ==== rtl/vdp_cmd_engine.sv ====
// Top of the VDP command engine, register file plus sequencer.
// The CPU register port and the VRAM toggle port are both exposed here.
`timescale 1ns/1ps

module vdp_cmd_engine (
  input  logic                              clk,
  input  logic                              reset,
  input  vdp_cmd_pkg::screen_mode_e         mode,
  input  logic                              reg_wr_req,
  input  vdp_reg_pkg::reg_index_e           reg_num,
  input  logic [7:0]                        reg_data,
  output logic                              reg_wr_ack,
  output logic                              vram_rd_req,
  output logic                              vram_wr_req,
  output logic [vdp_cmd_pkg::VRAM_ADDR_W-1:0] vram_addr,
  output logic [7:0]                        vram_wr_data,
  input  logic                              vram_rd_ack,
  input  logic                              vram_wr_ack,
  input  logic [7:0]                        vram_rd_data,
  output logic [7:0]                        clr,
  output logic                              ce
);
  import vdp_reg_pkg::*;
  import vdp_cmd_pkg::*;

  cmd_regs_t  regs;
  vram_req_t  vram;
  logic       cmd_start;
  logic       stall;
  logic       clr_load_valid;
  logic [7:0] clr_load_data;

  // CPU write pending, sequencer holds for this cycle
  assign stall = reg_wr_req != reg_wr_ack;

  vdp_cmd_regs u_regs (
    .clk            (clk),
    .reset          (reset),
    .mode           (mode),
    .reg_wr_req     (reg_wr_req),
    .reg_num        (reg_num),
    .reg_data       (reg_data),
    .clr_load_valid (clr_load_valid),
    .clr_load_data  (clr_load_data),
    .reg_wr_ack     (reg_wr_ack),
    .regs           (regs),
    .cmd_start      (cmd_start)
  );

  vdp_cmd_seq u_seq (
    .clk            (clk),
    .reset          (reset),
    .mode           (mode),
    .regs           (regs),
    .cmd_start      (cmd_start),
    .stall          (stall),
    .vram_rd_ack    (vram_rd_ack),
    .vram_wr_ack    (vram_wr_ack),
    .vram_rd_data   (vram_rd_data),
    .vram_rd_req    (vram_rd_req),
    .vram_wr_req    (vram_wr_req),
    .vram           (vram),
    .clr_load_valid (clr_load_valid),
    .clr_load_data  (clr_load_data),
    .ce             (ce)
  );

  // Flatten the request bundle onto the memory pins
  assign vram_addr    = vram.addr;
  assign vram_wr_data = vram.wr_data;
  assign clr          = regs.clr;

endmodule

// ==== tests/vdp_cmd_checker.sv ====
// Concurrent assertions on the CPU and VRAM handshakes of the command engine.
// Bound into every vdp_cmd_engine instance; failures are also counted in fail_count.
`timescale 1ns/1ps

module vdp_cmd_checker (
  input logic                   clk,
  input logic                   reset,
  input logic                   reg_wr_req,
  input logic                   reg_wr_ack,
  input logic                   vram_rd_req,
  input logic                   vram_rd_ack,
  input logic                   vram_wr_req,
  input logic                   vram_wr_ack,
  input vdp_cmd_pkg::vram_req_t vram,
  input logic                   ce
);
  int fail_count = 0;

  // Pending CPU write acknowledged on the next edge
  ack_follows_req: assert property (@(posedge clk) disable iff (reset)
    (reg_wr_req != reg_wr_ack) |=> (reg_wr_req == reg_wr_ack))
    else begin
      $error("reg_wr_ack did not follow reg_wr_req");
      fail_count++;
    end

  // Address and data frozen while an access is open
  bundle_stable: assert property (@(posedge clk) disable iff (reset)
    ((vram_rd_req != vram_rd_ack) || (vram_wr_req != vram_wr_ack)) |=> $stable(vram))
    else begin
      $error("VRAM request bundle changed during an open access");
      fail_count++;
    end

  // New VRAM requests only from a running command
  req_needs_ce: assert property (@(posedge clk) disable iff (reset)
    ($changed(vram_rd_req) || $changed(vram_wr_req)) |-> $past(ce))
    else begin
      $error("VRAM request toggled while ce was low");
      fail_count++;
    end

  // Quiet state right after reset
  reset_state: assert property (@(posedge clk)
    $fell(reset) |-> (!ce && !reg_wr_ack && (vram_rd_req == vram_rd_ack)
                      && (vram_wr_req == vram_wr_ack)))
    else begin
      $error("Engine not idle after reset");
      fail_count++;
    end

endmodule

bind vdp_cmd_engine vdp_cmd_checker u_checker (
  .clk         (clk),
  .reset       (reset),
  .reg_wr_req  (reg_wr_req),
  .reg_wr_ack  (reg_wr_ack),
  .vram_rd_req (vram_rd_req),
  .vram_rd_ack (vram_rd_ack),
  .vram_wr_req (vram_wr_req),
  .vram_wr_ack (vram_wr_ack),
  .vram        (vram),
  .ce          (ce)
);

// ==== tests/tb_vdp_cmd.sv ====
// Testbench for the VDP command engine with a toggle-handshake VRAM model.
// VRAM contents are checked against a shadow array updated by the drawing rules.
`timescale 1ns/1ps

module tb_vdp_cmd;
  import vdp_reg_pkg::*;
  import vdp_cmd_pkg::*;

  localparam int MEM_SIZE = 1 << VRAM_ADDR_W;
  localparam int CE_LIMIT = 200000;

  logic                   clk;
  logic                   reset;
  screen_mode_e           mode;
  logic                   reg_wr_req;
  reg_index_e             reg_num;
  logic [7:0]             reg_data;
  logic                   reg_wr_ack;
  logic                   vram_rd_req;
  logic                   vram_wr_req;
  logic [VRAM_ADDR_W-1:0] vram_addr;
  logic [7:0]             vram_wr_data;
  logic                   vram_rd_ack = 1'b0;
  logic                   vram_wr_ack = 1'b0;
  logic [7:0]             vram_rd_data = 8'h00;
  logic [7:0]             clr;
  logic                   ce;

  logic [7:0]  mem [MEM_SIZE];
  logic [7:0]  shadow [MEM_SIZE];
  logic [31:0] rng = 32'd78;
  int          errors = 0;
  int          mark = 0;
  int          tests_passed = 0;
  int          tests_failed = 0;
  int          ack_edges = 0;
  // Remaining delay of the open access, -1 when none drawn yet
  int          rd_wait = -1;
  int          wr_wait = -1;

  vdp_cmd_engine u_dut (
    .clk          (clk),
    .reset        (reset),
    .mode         (mode),
    .reg_wr_req   (reg_wr_req),
    .reg_num      (reg_num),
    .reg_data     (reg_data),
    .reg_wr_ack   (reg_wr_ack),
    .vram_rd_req  (vram_rd_req),
    .vram_wr_req  (vram_wr_req),
    .vram_addr    (vram_addr),
    .vram_wr_data (vram_wr_data),
    .vram_rd_ack  (vram_rd_ack),
    .vram_wr_ack  (vram_wr_ack),
    .vram_rd_data (vram_rd_data),
    .clr          (clr),
    .ce           (ce)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // LCG, upper half is the usable part
  function automatic logic [31:0] next_rand();
    rng = rng * 32'd1664525 + 32'd1013904223;
    return {16'h0000, rng[31:16]};
  endfunction

  // VRAM answers each toggle after 0 to 3 cycles
  always @(negedge clk) begin
    if (!reset) begin
      if (vram_rd_req != vram_rd_ack) begin
        if (rd_wait < 0) rd_wait = int'(next_rand() % 4);
        if (rd_wait == 0) begin
          vram_rd_data = mem[vram_addr];
          vram_rd_ack  = vram_rd_req;
          rd_wait      = -1;
        end else begin
          rd_wait--;
        end
      end
      if (vram_wr_req != vram_wr_ack) begin
        if (wr_wait < 0) wr_wait = int'(next_rand() % 4);
        if (wr_wait == 0) begin
          mem[vram_addr] = vram_wr_data;
          vram_wr_ack    = vram_wr_req;
          wr_wait        = -1;
        end else begin
          wr_wait--;
        end
      end
    end
  end

  // Every edge of the CPU acknowledge
  always @(reg_wr_ack) ack_edges++;

  function automatic int error_total();
    return errors + u_dut.u_checker.fail_count;
  endfunction

  task automatic check(input logic ok, input string msg);
    assert (ok) else begin
      $display("FAILED @%0t: %s", $time, msg);
      errors++;
    end
  endtask

  task automatic stop_on_timeout(input string what);
    $display("Timeout at %0t while waiting for %s", $time, what);
    $display("SOME TESTS FAILED");
    $finish;
  endtask

  // G4 keeps Y 9:0 over X 7:1, G7 keeps Y 8:0 over X 7:0
  function automatic logic [VRAM_ADDR_W-1:0] addr_of(input screen_mode_e m, input int x,
                                                      input int y);
    logic [7:0] xb;
    logic [9:0] yb;
    xb = 8'(x);
    yb = 10'(y);
    if (m == MODE_G4) begin
      return {yb, xb[7:1]};
    end
    return {yb[8:0], xb};
  endfunction

  // Even X lives in the high nibble
  function automatic logic [7:0] pixel_of(input screen_mode_e m, input int x, input int y);
    logic [7:0] b;
    b = shadow[addr_of(m, x, y)];
    if (m == MODE_G7) begin
      return b;
    end
    return x[0] ? {4'h0, b[3:0]} : {4'h0, b[7:4]};
  endfunction

  task automatic apply_pixel(input screen_mode_e m, input int x, input int y,
                             input logic [7:0] cmd, input logic [7:0] colour);
    logic [VRAM_ADDR_W-1:0] a;
    logic [7:0]             src;
    logic [7:0]             dst;
    logic [7:0]             res;
    a   = addr_of(m, x, y);
    dst = pixel_of(m, x, y);
    src = (m == MODE_G4) ? (colour & 8'h0f) : colour;
    // T bit with a zero colour leaves the pixel alone
    if (cmd[3] && (src == 8'h00)) begin
      res = dst;
    end else begin
      case (cmd[2:0])
        3'd0:    res = src;
        3'd1:    res = src & dst;
        3'd2:    res = src | dst;
        3'd3:    res = src ^ dst;
        3'd4:    res = ~src;
        default: res = dst;
      endcase
    end
    if (m == MODE_G7) begin
      shadow[a] = res;
    end else if (x[0]) begin
      shadow[a] = {shadow[a][7:4], res[3:0]};
    end else begin
      shadow[a] = {res[3:0], shadow[a][3:0]};
    end
  endtask

  // Rectangle walk, clipped at the X edges and at row 0 going up
  task automatic model_rect(input screen_mode_e m, input logic [7:0] cmd,
                            input logic [7:0] colour, input int dx, input int dy,
                            input int nx, input int ny, input logic dix, input logic diy);
    int x;
    int y;
    for (int r = 0; r < ny; r++) begin
      y = diy ? dy - r : dy + r;
      for (int i = 0; i < nx; i++) begin
        x = dix ? dx - i : dx + i;
        if (x < 0 || x > 255) break;
        if (cmd[7:4] == 4'hc) begin
          shadow[addr_of(m, x, y)] = colour;
        end else begin
          apply_pixel(m, x, y, cmd, colour);
        end
      end
      if (diy && y == 0) break;
    end
  endtask

  task automatic compare_mem(input string what);
    int bad;
    int first;
    bad   = 0;
    first = -1;
    for (int i = 0; i < MEM_SIZE; i++) begin
      if (mem[i] !== shadow[i]) begin
        if (first < 0) first = i;
        bad++;
      end
    end
    check(bad == 0, $sformatf("%s: %0d VRAM bytes wrong, first at 0x%05h", what, bad, first));
  endtask

  task automatic wait_ce(input logic level, input int limit);
    int n;
    n = 0;
    while (ce !== level && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (ce !== level) stop_on_timeout(level ? "ce to rise" : "ce to fall");
  endtask

  // One toggle request, then wait for the matching ack
  task automatic write_reg(input reg_index_e num, input logic [7:0] data);
    int   n;
    logic prev;
    @(negedge clk);
    prev       = reg_wr_ack;
    reg_num    = num;
    reg_data   = data;
    reg_wr_req = ~reg_wr_req;
    n = 0;
    while (reg_wr_ack == prev && n < 8) begin
      @(negedge clk);
      n++;
    end
    if (reg_wr_ack == prev) stop_on_timeout("reg_wr_ack");
  endtask

  task automatic write_word(input reg_index_e lo, input logic [15:0] v);
    write_reg(lo, v[7:0]);
    write_reg(reg_index_e'(lo + 4'd1), v[15:8]);
  endtask

  task automatic load_rect(input int sx, input int sy, input int dx, input int dy,
                           input int nx, input int ny, input logic [7:0] colour,
                           input logic [7:0] arg);
    write_word(REG_SX_LO, 16'(sx));
    write_word(REG_SY_LO, 16'(sy));
    write_word(REG_DX_LO, 16'(dx));
    write_word(REG_DY_LO, 16'(dy));
    write_word(REG_NX_LO, 16'(nx));
    write_word(REG_NY_LO, 16'(ny));
    write_reg(REG_CLR, colour);
    write_reg(REG_ARG, arg);
  endtask

  task automatic run_cmd(input logic [7:0] cmd);
    write_reg(REG_CMD, cmd);
    wait_ce(1'b1, 4);
    wait_ce(1'b0, CE_LIMIT);
  endtask

  task automatic end_test(input string name);
    if (error_total() == mark) begin
      tests_passed++;
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, error_total() - mark);
    end
    mark = error_total();
  endtask

  initial begin
    int         dx;
    int         dy;
    int         nx;
    int         ny;
    int         edges0;
    logic [7:0] c;
    logic       rd_q;
    logic       wr_q;
    reset      = 1'b1;
    mode       = MODE_G7;
    reg_wr_req = 1'b0;
    reg_num    = REG_SX_LO;
    reg_data   = 8'h00;
    for (int i = 0; i < MEM_SIZE; i++) begin
      mem[i]    = 8'(next_rand());
      shadow[i] = mem[i];
    end
    repeat (16) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    mark = error_total();

    // All 15 offsets, CMD left at STOP
    edges0 = ack_edges;
    for (int i = 0; i < 15; i++) begin
      write_reg(reg_index_e'(i), (i == 14) ? 8'h00 : 8'(next_rand()));
    end
    @(negedge clk);
    check(ack_edges - edges0 == 15, $sformatf("%0d ack edges for 15 writes", ack_edges - edges0));
    end_test("register writes");

    // HMMV in G7, walking left and up
    mode = MODE_G7;
    dx = int'(next_rand() % 256);
    nx = 1 + int'(next_rand() % 48);
    dy = int'(next_rand() % 200);
    ny = 1 + int'(next_rand() % 24);
    c  = 8'(next_rand());
    load_rect(0, 0, dx, dy, nx, ny, c, 8'h0c);
    run_cmd(8'hc0);
    model_rect(MODE_G7, 8'hc0, c, dx, dy, nx, ny, 1'b1, 1'b1);
    compare_mem("HMMV G7");
    end_test("HMMV G7");

    // LMMV XOR in G4, odd start and odd width
    mode = MODE_G4;
    dx = 2 * int'(next_rand() % 120) + 1;
    nx = 2 * int'(next_rand() % 20) + 1;
    dy = int'(next_rand() % 900);
    ny = 1 + int'(next_rand() % 16);
    c  = 8'(next_rand());
    load_rect(0, 0, dx, dy, nx, ny, c, 8'h00);
    run_cmd(8'h83);
    model_rect(MODE_G4, 8'h83, c, dx, dy, nx, ny, 1'b0, 1'b0);
    compare_mem("LMMV XOR G4");
    end_test("LMMV XOR G4");

    // Transparent zero fill, then a single PSET AND
    mode = MODE_G7;
    dx = int'(next_rand() % 200);
    dy = int'(next_rand() % 400);
    load_rect(0, 0, dx, dy, 30, 10, 8'h00, 8'h00);
    run_cmd(8'h88);
    model_rect(MODE_G7, 8'h88, 8'h00, dx, dy, 30, 10, 1'b0, 1'b0);
    compare_mem("LMMV transparent");
    dx = int'(next_rand() % 256);
    dy = int'(next_rand() % 400);
    c  = 8'(next_rand()) | 8'h01;
    load_rect(0, 0, dx, dy, 1, 1, c, 8'h00);
    run_cmd(8'h59);
    apply_pixel(MODE_G7, dx, dy, 8'h59, c);
    compare_mem("PSET AND");
    end_test("transparency");

    // PSET then POINT at the same spot, once per mode
    for (int k = 0; k < 2; k++) begin
      mode = (k == 0) ? MODE_G4 : MODE_G7;
      dx = int'(next_rand() % 256);
      dy = int'(next_rand() % 400);
      c  = 8'(next_rand());
      load_rect(dx, dy, dx, dy, 1, 1, c, 8'h00);
      run_cmd(8'h50);
      apply_pixel(mode, dx, dy, 8'h50, c);
      write_reg(REG_CLR, ~c);
      run_cmd(8'h40);
      check(clr == pixel_of(mode, dx, dy),
            $sformatf("POINT read %02h, expected %02h", clr, pixel_of(mode, dx, dy)));
    end
    compare_mem("PSET before POINT");
    end_test("POINT");

    // STOP in the middle of a long HMMV
    mode = MODE_G7;
    load_rect(0, 0, 0, 0, 256, 300, 8'(next_rand()), 8'h00);
    write_reg(REG_CMD, 8'hc0);
    wait_ce(1'b1, 4);
    repeat (40) @(negedge clk);
    check(ce == 1'b1, "large HMMV ended before the abort");
    write_reg(REG_CMD, 8'h00);
    wait_ce(1'b0, 4);
    rd_q = vram_rd_req;
    wr_q = vram_wr_req;
    for (int i = 0; i < 50; i++) begin
      @(negedge clk);
      check(vram_rd_req == rd_q && vram_wr_req == wr_q, "VRAM request issued after STOP");
    end
    end_test("abort");

    $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
    if (tests_failed == 0 && error_total() == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
rtl/vdp_reg_pkg.sv
rtl/vdp_cmd_pkg.sv
rtl/vdp_pixel_alu.sv
rtl/vdp_cmd_regs.sv
rtl/vdp_cmd_seq.sv
rtl/vdp_cmd_engine.sv
tests/vdp_cmd_checker.sv
tests/tb_vdp_cmd.sv

// ==== run.sh ====
#!/bin/sh
# Build the command engine testbench with Verilator, run it, and judge the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_vdp_cmd \
  -f sources.f -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_vdp_cmd > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "^ALL TESTS PASSED$" sim.log; then
  exit 0
fi
exit 1
